// File: source/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath width in bits
`define XLEN 32

// architectural register count, x0 included
`define REG_COUNT 32

// bits needed to index one register
`define REG_ID_W 5

`endif

// File: source/isa_pkg.sv
package isa_pkg;

  // rv32 base word, fields in encoding order from bit 31 down
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instruction_t;

  // major opcodes this core understands
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_t;

  // funct3 values shared by register and immediate alu ops
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_t;

  // funct7 bit 5, i.e. instruction bit 30, picks sub and sra
  localparam int unsigned FUNCT7_ALT_BIT = 5;

  // instruction formats, anything else is illegal
  typedef enum logic [2:0] {
    R_TYPE  = 3'd0,
    I_TYPE  = 3'd1,
    U_TYPE  = 3'd2,
    ILLEGAL = 3'd3
  } encoding_t;

  // alu operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHIFT_LEFT,
    ALU_SHIFT_RIGHT,
    ALU_SHIFT_RIGHT_AR,
    ALU_LESS_THAN_SIGNED,
    ALU_LESS_THAN_UNSIGNED
  } alu_op_t;

endpackage

// File: source/pipe_pkg.sv
`include "core_params.svh"

package pipe_pkg;

  // per-instruction control, produced in decode
  typedef struct packed {
    isa_pkg::encoding_t encoding;
    isa_pkg::alu_op_t   alu_op;
    // operand b from the immediate
    logic               alu_src;
    // low for lui, operand a is then zero
    logic               use_rs1;
    logic               reg_write;
  } control_t;

  // writeback payload
  // also what the retire port reports
  typedef struct packed {
    logic [`REG_ID_W-1:0] rd;
    logic [`XLEN-1:0]     result;
    logic                 reg_write;
  } wb_t;

endpackage

// File: source/pipe_ifs.sv
`timescale 1ns/1ps

`include "core_params.svh"

// decode to execute stage register
interface id_ex_if;

  // one-cycle strobe per instruction
  logic                 valid;
  pipe_pkg::control_t   control;
  logic [`REG_ID_W-1:0] rs1;
  logic [`REG_ID_W-1:0] rs2;
  logic [`XLEN-1:0]     read1_data;
  logic [`XLEN-1:0]     read2_data;
  logic [`XLEN-1:0]     immediate_data;
  logic [`REG_ID_W-1:0] rd;

  modport decode (
    output valid, control, rs1, rs2, read1_data, read2_data, immediate_data, rd
  );

  modport execute (
    input valid, control, rs1, rs2, read1_data, read2_data, immediate_data, rd
  );

endinterface

// writeback register, feeds the register file and both bypasses
interface wb_if;

  logic          valid;
  pipe_pkg::wb_t data;

  // execute owns the register
  modport source (output valid, data);
  // decode, register file write port and write-through
  modport sink (input valid, data);
  // execute reading its own result back for operand forwarding
  modport forward (input valid, data);

endinterface

// File: source/control.sv
`timescale 1ns/1ps

module control (
  input  isa_pkg::instruction_t instruction,
  output pipe_pkg::control_t    control
);

  // instruction bit 30
  logic alt;

  // funct3 to alu op
  // sub_sel only matters for register ops, sra_sel for both
  function automatic isa_pkg::alu_op_t alu_decode(
    input logic [2:0] funct3,
    input logic       sub_sel,
    input logic       sra_sel
  );
    isa_pkg::alu_op_t op;
    case (funct3)
      isa_pkg::F3_ADD_SUB: begin
        if (sub_sel) begin
          op = isa_pkg::ALU_SUB;
        end else begin
          op = isa_pkg::ALU_ADD;
        end
      end
      isa_pkg::F3_SLL:  op = isa_pkg::ALU_SHIFT_LEFT;
      isa_pkg::F3_SLT:  op = isa_pkg::ALU_LESS_THAN_SIGNED;
      isa_pkg::F3_SLTU: op = isa_pkg::ALU_LESS_THAN_UNSIGNED;
      isa_pkg::F3_XOR:  op = isa_pkg::ALU_XOR;
      isa_pkg::F3_SRL_SRA: begin
        if (sra_sel) begin
          op = isa_pkg::ALU_SHIFT_RIGHT_AR;
        end else begin
          op = isa_pkg::ALU_SHIFT_RIGHT;
        end
      end
      isa_pkg::F3_OR:   op = isa_pkg::ALU_OR;
      default:          op = isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign alt = instruction.funct7[isa_pkg::FUNCT7_ALT_BIT];

  always_comb begin
    // safe default, no write
    control          = '0;
    control.encoding = isa_pkg::ILLEGAL;
    control.alu_op   = isa_pkg::ALU_ADD;
    case (instruction.opcode)
      isa_pkg::OP: begin
        control.encoding  = isa_pkg::R_TYPE;
        control.alu_op    = alu_decode(instruction.funct3, alt, alt);
        control.use_rs1   = 1'b1;
        control.reg_write = 1'b1;
      end
      isa_pkg::OP_IMM: begin
        // no subi, bit 30 is part of the immediate except for srai
        control.encoding  = isa_pkg::I_TYPE;
        control.alu_op    = alu_decode(instruction.funct3, 1'b0, alt);
        control.alu_src   = 1'b1;
        control.use_rs1   = 1'b1;
        control.reg_write = 1'b1;
      end
      isa_pkg::LUI: begin
        // zero plus upper immediate
        control.encoding  = isa_pkg::U_TYPE;
        control.alu_op    = isa_pkg::ALU_ADD;
        control.alu_src   = 1'b1;
        control.reg_write = 1'b1;
      end
      default: begin
        // retires without touching the register file
        control.reg_write = 1'b0;
      end
    endcase
  end

endmodule

// File: source/imm_gen.sv
`timescale 1ns/1ps

`include "core_params.svh"

module imm_gen (
  input  isa_pkg::instruction_t instruction,
  input  isa_pkg::encoding_t    encoding,
  output logic [`XLEN-1:0]      immediate_data
);

  // i-type field, bits 31:20
  logic [11:0] imm_i;
  // u-type field, bits 31:12
  logic [19:0] imm_u;

  assign imm_i = {instruction.funct7, instruction.rs2};
  assign imm_u = {instruction.funct7, instruction.rs2, instruction.rs1, instruction.funct3};

  always_comb begin
    immediate_data = '0;
    case (encoding)
      isa_pkg::I_TYPE: begin
        // sign extend, shifts later use only the low bits
        immediate_data = {{(`XLEN-12){imm_i[11]}}, imm_i};
      end
      isa_pkg::U_TYPE: begin
        // upper field, low 12 bits stay zero
        immediate_data[31:12] = imm_u;
      end
      default: begin
        immediate_data = '0;
      end
    endcase
  end

endmodule

// File: source/registers.sv
`timescale 1ns/1ps

`include "core_params.svh"

module registers (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`REG_ID_W-1:0] read1_id,
  input  logic [`REG_ID_W-1:0] read2_id,
  input  logic                 write_en,
  input  logic [`REG_ID_W-1:0] write_id,
  input  logic [`XLEN-1:0]     write_data,
  output logic [`XLEN-1:0]     read1_data,
  output logic [`XLEN-1:0]     read2_data
);

  logic [`XLEN-1:0] regs [`REG_COUNT];

  // synchronous write, x0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (write_id != '0)) begin
      regs[write_id] <= write_data;
    end
  end

  // combinational read ports
  assign read1_data = regs[read1_id];
  assign read2_data = regs[read2_id];

  // x0 stays zero through any write stream
  a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
    else $error("register x0 holds a nonzero value");

endmodule

// File: source/instruction_decode_stage.sv
`timescale 1ns/1ps

`include "core_params.svh"

module instruction_decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  isa_pkg::instruction_t instr,
  wb_if.sink                    wb,
  id_ex_if.decode               id_ex
);

  // instruction register
  isa_pkg::instruction_t instr_q;
  logic                  instr_valid_q;

  // decoded fields of the held word
  pipe_pkg::control_t   ctrl;
  pipe_pkg::control_t   issue_ctrl;
  logic [`XLEN-1:0]     imm;
  logic [`REG_ID_W-1:0] rs1;
  logic [`REG_ID_W-1:0] rs2;

  // register file reads, before and after write-through
  logic [`XLEN-1:0] reg_read1;
  logic [`XLEN-1:0] reg_read2;
  logic [`XLEN-1:0] read1_bypassed;
  logic [`XLEN-1:0] read2_bypassed;

  // writeback actually writes this cycle
  logic wb_write;

  // capture the incoming word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else begin
      instr_valid_q <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    instr_q <= instr;
  end

  assign rs1 = instr_q.rs1;
  assign rs2 = instr_q.rs2;

  control control_inst (
    .instruction(instr_q),
    .control    (ctrl)
  );

  imm_gen imm_gen_inst (
    .instruction   (instr_q),
    .encoding      (ctrl.encoding),
    .immediate_data(imm)
  );

  assign wb_write = wb.valid && wb.data.reg_write;

  registers registers_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .read1_id  (rs1),
    .read2_id  (rs2),
    .write_en  (wb_write),
    .write_id  (wb.data.rd),
    .write_data(wb.data.result),
    .read1_data(reg_read1),
    .read2_data(reg_read2)
  );

  // write-through, the producer two ahead is being written right now
  always_comb begin
    read1_bypassed = reg_read1;
    read2_bypassed = reg_read2;
    if (wb_write && (wb.data.rd == rs1) && (rs1 != '0)) begin
      read1_bypassed = wb.data.result;
    end
    if (wb_write && (wb.data.rd == rs2) && (rs2 != '0)) begin
      read2_bypassed = wb.data.result;
    end
  end

  // rd of zero never writes, so later stages can trust reg_write
  always_comb begin
    issue_ctrl           = ctrl;
    issue_ctrl.reg_write = ctrl.reg_write && (instr_q.rd != '0);
  end

  // id_ex register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid <= instr_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    id_ex.control        <= issue_ctrl;
    id_ex.rs1            <= rs1;
    id_ex.rs2            <= rs2;
    id_ex.read1_data     <= read1_bypassed;
    id_ex.read2_data     <= read2_bypassed;
    id_ex.immediate_data <= imm;
    id_ex.rd             <= instr_q.rd;
  end

  // whatever the word held, execute only ever sees a known format
  a_encoding_known: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex.valid |-> id_ex.control.encoding inside
      {isa_pkg::R_TYPE, isa_pkg::I_TYPE, isa_pkg::U_TYPE, isa_pkg::ILLEGAL})
    else $error("id_ex carries an unknown encoding");

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

`include "core_params.svh"

module execute_stage (
  input  logic      clk,
  input  logic      rst_n,
  id_ex_if.execute  id_ex,
  wb_if.source      wb,
  wb_if.forward     fwd
);

  localparam int SHAMT_W = $clog2(`XLEN);

  // forward hits from the writeback register
  logic fwd1;
  logic fwd2;

  // register operands after forwarding
  logic [`XLEN-1:0] rs1_value;
  logic [`XLEN-1:0] rs2_value;

  // alu inputs and output
  logic [`XLEN-1:0]   operand_a;
  logic [`XLEN-1:0]   operand_b;
  logic [SHAMT_W-1:0] shamt;
  logic [`XLEN-1:0]   alu_result;

  // previous instruction wrote the register we read
  assign fwd1 = fwd.valid && fwd.data.reg_write && (fwd.data.rd == id_ex.rs1)
                && (id_ex.rs1 != '0);
  assign fwd2 = fwd.valid && fwd.data.reg_write && (fwd.data.rd == id_ex.rs2)
                && (id_ex.rs2 != '0);

  assign rs1_value = fwd1 ? fwd.data.result : id_ex.read1_data;
  assign rs2_value = fwd2 ? fwd.data.result : id_ex.read2_data;

  // lui adds to zero
  assign operand_a = id_ex.control.use_rs1 ? rs1_value : '0;
  assign operand_b = id_ex.control.alu_src ? id_ex.immediate_data : rs2_value;

  // shift amount, also the shamt field of the immediate forms
  assign shamt = operand_b[SHAMT_W-1:0];

  always_comb begin
    alu_result = '0;
    case (id_ex.control.alu_op)
      isa_pkg::ALU_ADD:            alu_result = operand_a + operand_b;
      isa_pkg::ALU_SUB:            alu_result = operand_a - operand_b;
      isa_pkg::ALU_AND:            alu_result = operand_a & operand_b;
      isa_pkg::ALU_OR:             alu_result = operand_a | operand_b;
      isa_pkg::ALU_XOR:            alu_result = operand_a ^ operand_b;
      isa_pkg::ALU_SHIFT_LEFT:     alu_result = operand_a << shamt;
      isa_pkg::ALU_SHIFT_RIGHT:    alu_result = operand_a >> shamt;
      // sign bit fills from the left
      isa_pkg::ALU_SHIFT_RIGHT_AR: alu_result = $signed(operand_a) >>> shamt;
      isa_pkg::ALU_LESS_THAN_SIGNED: begin
        alu_result[0] = $signed(operand_a) < $signed(operand_b);
      end
      isa_pkg::ALU_LESS_THAN_UNSIGNED: begin
        alu_result[0] = operand_a < operand_b;
      end
      default: alu_result = '0;
    endcase
  end

  // writeback register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= id_ex.valid;
    end
  end

  // write flag follows valid so idle slots never write
  always_ff @(posedge clk) begin
    wb.data.rd        <= id_ex.rd;
    wb.data.result    <= alu_result;
    wb.data.reg_write <= id_ex.valid && id_ex.control.reg_write;
  end

  // decode drops writes toward x0 before they get here
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
    (id_ex.valid && id_ex.control.reg_write) |-> (id_ex.rd != '0))
    else $error("write toward x0 reached execute");

endmodule

// File: source/core_pipeline.sv
`timescale 1ns/1ps

`include "core_params.svh"

module core_pipeline (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  logic [31:0]          instr,
  output logic                 retire_valid,
  output logic [`REG_ID_W-1:0] retire_rd,
  output logic [`XLEN-1:0]     retire_result,
  output logic                 retire_write
);

  // stage links
  id_ex_if id_ex ();
  wb_if    wb ();

  instruction_decode_stage decode_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr_valid(instr_valid),
    .instr      (isa_pkg::instruction_t'(instr)),
    .wb         (wb.sink),
    .id_ex      (id_ex.decode)
  );

  // execute drives wb and reads it back for forwarding
  execute_stage execute_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .id_ex(id_ex.execute),
    .wb   (wb.source),
    .fwd  (wb.forward)
  );

  // retire port is the writeback register as seen from outside
  assign retire_valid  = wb.valid;
  assign retire_rd     = wb.data.rd;
  assign retire_result = wb.data.result;
  assign retire_write  = wb.data.reg_write;

endmodule

// File: tests/tb_core_pipeline.sv
`timescale 1ns/1ps

`include "core_params.svh"

module tb_core_pipeline;

  localparam int PERIOD       = 100;
  localparam int RESET_CYCLES = 10;
  localparam int N_INSTR      = 2000;
  localparam int DRIVE_DELAY  = 1;
  // issue slot to retire cycle
  localparam int LATENCY      = 3;
  // at most one idle slot per instruction, plus drain margin
  localparam int WATCHDOG_NS  = (RESET_CYCLES + 2 * N_INSTR + 50) * PERIOD;

  // rv32i major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // one predicted retire
  typedef struct {
    logic [4:0]        rd;
    logic [`XLEN-1:0]  result;
    logic              write;
    int                due;
  } retire_t;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic                 retire_valid;
  logic [`REG_ID_W-1:0] retire_rd;
  logic [`XLEN-1:0]     retire_result;
  logic                 retire_write;

  // architectural state of the model
  logic [`XLEN-1:0] model_regs [`REG_COUNT];
  retire_t          expq [$];

  // posedge count, read at negedge
  int cycle   = 0;

  core_pipeline UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_result(retire_result),
    .retire_write (retire_write)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // wrong value, hex dump then stop
  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
    $display("** FAIL **");
    $fatal(1, "mismatch on %s", name);
  endtask

  // failure that is not a value compare
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "%s", what);
  endtask

  // small register set, dependencies are frequent
  function automatic logic [4:0] pick_reg();
    return 5'($urandom_range(0, 4));
  endfunction

  // rv32i alu semantics by funct3, alt is instruction bit 30
  function automatic logic [31:0] alu_reference(input logic [2:0] f3, input logic alt,
                                                input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'b000: begin
        if (alt) begin
          r = a - b;
        end else begin
          r = a + b;
        end
      end
      3'b001: r = a << b[4:0];
      3'b010: r = {31'b0, $signed(a) < $signed(b)};
      3'b011: r = {31'b0, a < b};
      3'b100: r = a ^ b;
      3'b101: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // random word, mostly legal alu ops
  task automatic make_instr(output logic [31:0] word);
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [6:0]  opc;
    kind = $urandom_range(0, 19);
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = 3'($urandom_range(0, 7));
    if (kind < 8) begin
      // r-type, bit 30 only on add/sub and srl/sra
      f7 = 7'b0;
      if (((f3 == 3'b000) || (f3 == 3'b101)) && ($urandom_range(0, 1) == 1)) begin
        f7 = 7'b0100000;
      end
      word = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 15) begin
      imm = 12'($urandom);
      // shift immediates carry shamt in the low five bits
      if (f3 == 3'b001) begin
        imm = {7'b0, imm[4:0]};
      end else if (f3 == 3'b101) begin
        imm = {1'b0, imm[10], 5'b0, imm[4:0]};
      end
      word = {imm, rs1, f3, rd, OPC_OP_IMM};
    end else if (kind < 18) begin
      word = {20'($urandom), rd, OPC_LUI};
    end else begin
      // anything outside the supported opcodes
      do begin
        opc = 7'($urandom);
      end while ((opc == OPC_OP) || (opc == OPC_OP_IMM) || (opc == OPC_LUI));
      word = {25'($urandom), opc};
    end
  endtask

  // sequential model, one instruction at issue time
  task automatic predict_retire(input logic [31:0] word);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic        wr;
    retire_t     e;
    opc   = word[6:0];
    rd    = word[11:7];
    f3    = word[14:12];
    a     = model_regs[word[19:15]];
    b     = model_regs[word[24:20]];
    imm_i = {{20{word[31]}}, word[31:20]};
    res   = '0;
    wr    = 1'b0;
    case (opc)
      OPC_OP: begin
        res = alu_reference(f3, word[30], a, b);
        wr  = 1'b1;
      end
      OPC_OP_IMM: begin
        // bit 30 only selects srai
        res = alu_reference(f3, (f3 == 3'b101) && word[30], a, imm_i);
        wr  = 1'b1;
      end
      OPC_LUI: begin
        res = {word[31:12], 12'b0};
        wr  = 1'b1;
      end
      default: begin
        wr = 1'b0;
      end
    endcase
    // x0 never written
    if (rd == 5'd0) begin
      wr = 1'b0;
    end
    if (wr) begin
      model_regs[rd] = res;
    end
    e.rd     = rd;
    e.result = res;
    e.write  = wr;
    e.due    = cycle + LATENCY;
    expq.push_back(e);
  endtask

  // mid-cycle compare of the retire port
  task automatic check_retire();
    retire_t e;
    logic    due_now;
    due_now = (expq.size() > 0) && (expq[0].due == cycle);
    assert (retire_valid === due_now) else begin
      report_mismatch("retire_valid", {31'b0, due_now}, {31'b0, retire_valid});
    end
    if (due_now) begin
      e = expq.pop_front();
      assert (retire_rd === e.rd) else begin
        report_mismatch("retire_rd", {27'b0, e.rd}, {27'b0, retire_rd});
      end
      assert (retire_write === e.write) else begin
        report_mismatch("retire_write", {31'b0, e.write}, {31'b0, retire_write});
      end
      // result only defined when something is written
      if (e.write) begin
        assert (retire_result === e.result) else begin
          report_mismatch("retire_result", e.result, retire_result);
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (cycle > 0) begin
      check_retire();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all instructions retired");
  end

  initial begin
    logic [31:0] word;
    void'($urandom(56));
    for (int r = 0; r < `REG_COUNT; r++) begin
      model_regs[r] = '0;
    end
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    for (int i = 0; i < N_INSTR; i++) begin
      // roughly one slot in eight idle, junk on the bus
      if ($urandom_range(0, 7) == 0) begin
        instr_valid = 1'b0;
        instr       = $urandom;
        @(posedge clk);
        #(DRIVE_DELAY);
      end
      make_instr(word);
      instr_valid = 1'b1;
      instr       = word;
      predict_retire(word);
      @(posedge clk);
      #(DRIVE_DELAY);
    end
    instr_valid = 1'b0;
    instr       = '0;
    // drain, then a few quiet cycles
    while (expq.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: list.f
+incdir+source
source/isa_pkg.sv
source/pipe_pkg.sv
source/pipe_ifs.sv
source/control.sv
source/imm_gen.sv
source/registers.sv
source/instruction_decode_stage.sv
source/execute_stage.sv
source/core_pipeline.sv
tests/tb_core_pipeline.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, and judge the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_core_pipeline -f list.f \
  && ./obj_dir/Vtb_core_pipeline > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1
grep -q '\*\* PASS \*\*' sim.log || exit 1
exit 0
